// ==== include/rcc_defs.svh ====
`ifndef RCC_DEFS_SVH
`define RCC_DEFS_SVH

// --------------------------------------------------
// bdcr register geometry
// --------------------------------------------------

// register width in bits
`define RCC_BDCR_W 24

// writable bits only
// bit 0 lseon, 2 lsebyp, 4:3 lsedrv, 5 lsecsson
// bit 9:8 rtcsel, 15 rtcen, 16 bdrst
// lserdy (1) and lsecssd (6) are read-only
`define RCC_BDCR_RSVD_MASK 24'h01_833D

// --------------------------------------------------
// request path and clock security
// --------------------------------------------------

// request buffer entries, power of two
`define RCC_FIFO_DEPTH 4

// cycles without an lse tick before failure
`define RCC_CSS_TIMEOUT 16

`endif

// ==== design/rcc_pkg.sv ====
`include "rcc_defs.svh"

package rcc_pkg;

  // --------------------------------------------------
  // opcodes and field encodings
  // --------------------------------------------------

  // bus request kind
  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } rcc_op_e;

  // rtc clock source
  typedef enum logic [1:0] {
    rtc_none = 2'b00,
    rtc_lse  = 2'b01,
    rtc_lsi  = 2'b10,
    rtc_hse  = 2'b11
  } rcc_rtcsel_e;

  // --------------------------------------------------
  // bus payloads
  // --------------------------------------------------

  // one byte enable per register byte
  typedef struct packed {
    rcc_op_e                op;
    logic [2:0]             be;
    logic [`RCC_BDCR_W-1:0] wdata;
  } rcc_req_t;

  // read data only, no error status
  typedef struct packed {
    logic [`RCC_BDCR_W-1:0] rdata;
  } rcc_rsp_t;

  // field outputs, msb first as in the register
  typedef struct packed {
    logic        bdrst;
    logic        rtcen;
    rcc_rtcsel_e rtcsel;
    logic        lsecssd;
    logic        lsecsson;
    logic [1:0]  lsedrv;
    logic        lsebyp;
    logic        lseon;
  } rcc_bdcr_t;

endpackage

// ==== design/rcc_bus_if.sv ====
`include "rcc_defs.svh"

module rcc_bus_if (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              req_valid,
  output logic              req_ready,
  input  rcc_pkg::rcc_req_t req,
  input  logic              dbp,
  output logic              push_valid,
  input  logic              push_ready,
  output rcc_pkg::rcc_req_t push_req
);

  logic              accept;
  logic              is_write;
  logic              keep;
  rcc_pkg::rcc_req_t fwd_req;

  // --------------------------------------------------
  // acceptance and filtering
  // --------------------------------------------------

  // stage free, or emptied at this same edge
  assign req_ready = !push_valid || push_ready;
  assign accept    = req_valid && req_ready;
  assign is_write  = (req.op == rcc_pkg::op_write);

  // writes without dbp are taken and thrown away
  assign keep = accept && (!is_write || dbp);

  // reads pass as they are
  // writes lose their reserved and read-only bits
  always_comb begin
    fwd_req = req;
    if (is_write) begin
      fwd_req.wdata = req.wdata & `RCC_BDCR_RSVD_MASK;
    end
  end

  // --------------------------------------------------
  // output stage towards the fifo
  // --------------------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      push_valid <= 1'b0;
    end else if (keep) begin
      push_valid <= 1'b1;
    end else if (push_ready) begin
      // drained, nothing new behind it
      push_valid <= 1'b0;
    end
  end

  // payload only moves on a kept request
  always_ff @(posedge clk) begin
    if (keep) begin
      push_req <= fwd_req;
    end
  end

  // stalled entry must not change under the fifo
  a_push_hold : assert property (
    @(posedge clk) disable iff (!arst_n)
    push_valid && !push_ready |=> push_valid && $stable(push_req)
  );

endmodule

// ==== design/rcc_req_fifo.sv ====
`include "rcc_defs.svh"

module rcc_req_fifo (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              push_valid,
  output logic              push_ready,
  input  rcc_pkg::rcc_req_t push_req,
  output logic              pop_valid,
  input  logic              pop_ready,
  output rcc_pkg::rcc_req_t pop_req
);

  localparam int DEPTH = `RCC_FIFO_DEPTH;
  localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW    = $clog2(DEPTH + 1);

  rcc_pkg::rcc_req_t mem [DEPTH];
  logic [AW-1:0]     wr_ptr;
  logic [AW-1:0]     rd_ptr;
  logic [CW-1:0]     count;
  logic              push_fire;
  logic              pop_fire;

  // --------------------------------------------------
  // handshakes
  // --------------------------------------------------

  assign push_ready = (count != CW'(DEPTH));
  assign pop_valid  = (count != '0);
  assign push_fire  = push_valid && push_ready;
  assign pop_fire   = pop_valid && pop_ready;

  // head entry straight from storage
  assign pop_req = mem[rd_ptr];

  // --------------------------------------------------
  // pointers and fill count
  // --------------------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_fire) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_fire) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop keeps the count
      count <= count + CW'(push_fire) - CW'(pop_fire);
    end
  end

  // storage, no reset
  always_ff @(posedge clk) begin
    if (push_fire) begin
      mem[wr_ptr] <= push_req;
    end
  end

  // push while full or pop while empty would break this
  a_ptr_count : assert property (
    @(posedge clk) disable iff (!arst_n)
    (count <= CW'(DEPTH)) &&
    ((wr_ptr == rd_ptr) == ((count == '0) || (count == CW'(DEPTH))))
  );

endmodule

// ==== design/rcc_vsw_reg.sv ====
`include "rcc_defs.svh"

module rcc_vsw_reg (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               pop_valid,
  output logic               pop_ready,
  input  rcc_pkg::rcc_req_t  pop_req,
  input  logic               css_fail,
  input  logic               lse_rdy,
  output logic               rsp_valid,
  input  logic               rsp_ready,
  output rcc_pkg::rcc_rsp_t  rsp,
  output rcc_pkg::rcc_bdcr_t bdcr
);

  rcc_pkg::rcc_bdcr_t     bdcr_q;
  logic                   rtcsel_lock;
  logic                   lsecsson_lock;
  logic                   rtcsel_open;
  logic                   lsecsson_open;
  logic                   pop_fire;
  logic                   wr_fire;
  logic                   rd_fire;
  logic [`RCC_BDCR_W-1:0] wdata;
  logic [`RCC_BDCR_W-1:0] image;

  // --------------------------------------------------
  // request consumption
  // --------------------------------------------------

  // no pending response, or it leaves this edge
  assign pop_ready = !rsp_valid || rsp_ready;
  assign pop_fire  = pop_valid && pop_ready;
  assign wr_fire   = pop_fire && (pop_req.op == rcc_pkg::op_write);
  assign rd_fire   = pop_fire && (pop_req.op == rcc_pkg::op_read);
  assign wdata     = pop_req.wdata;

  // a failure at this edge already lets the write through
  assign rtcsel_open   = !rtcsel_lock || css_fail;
  assign lsecsson_open = !lsecsson_lock || css_fail;

  // --------------------------------------------------
  // bdcr fields
  // --------------------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bdcr_q        <= '0;
      rtcsel_lock   <= 1'b0;
      lsecsson_lock <= 1'b0;
    end else begin
      // lse failure: sticky flag, both locks reopen
      if (css_fail) begin
        bdcr_q.lsecssd <= 1'b1;
        rtcsel_lock    <= 1'b0;
        lsecsson_lock  <= 1'b0;
      end
      // byte 2, bdrst
      if (wr_fire && pop_req.be[2]) begin
        bdcr_q.bdrst <= wdata[16];
      end
      // byte 1, rtcen plain, rtcsel write-once
      if (wr_fire && pop_req.be[1]) begin
        bdcr_q.rtcen <= wdata[15];
        if (rtcsel_open) begin
          bdcr_q.rtcsel <= rcc_pkg::rcc_rtcsel_e'(wdata[9:8]);
          // a nonzero source closes the lock
          rtcsel_lock   <= (wdata[9:8] != 2'b00);
        end
      end
      // byte 0, lse controls
      if (wr_fire && pop_req.be[0]) begin
        bdcr_q.lseon  <= wdata[0];
        bdcr_q.lsebyp <= wdata[2];
        bdcr_q.lsedrv <= wdata[4:3];
        // set-only until the next failure
        if (lsecsson_open) begin
          bdcr_q.lsecsson <= wdata[5];
          lsecsson_lock   <= wdata[5];
        end
      end
    end
  end

  assign bdcr = bdcr_q;

  // --------------------------------------------------
  // read image and response channel
  // --------------------------------------------------

  // reserved bits read as zero, lserdy live in bit 1
  assign image = {7'b0, bdcr_q.bdrst, bdcr_q.rtcen, 5'b0, bdcr_q.rtcsel,
                  1'b0, bdcr_q.lsecssd, bdcr_q.lsecsson, bdcr_q.lsedrv,
                  bdcr_q.lsebyp, lse_rdy, bdcr_q.lseon};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rsp_valid <= 1'b0;
    end else if (rd_fire) begin
      rsp_valid <= 1'b1;
    end else if (rsp_ready) begin
      rsp_valid <= 1'b0;
    end
  end

  // held while rsp_ready is low
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rsp.rdata <= image;
    end
  end

  // only reset clears the failure flag
  a_lsecssd_sticky : assert property (
    @(posedge clk) disable iff (!arst_n)
    !$fell(bdcr_q.lsecssd)
  );

endmodule

// ==== design/rcc_lse_css.sv ====
`include "rcc_defs.svh"

module rcc_lse_css (
  input  logic               clk,
  input  logic               arst_n,
  input  rcc_pkg::rcc_bdcr_t bdcr,
  input  logic               lse_rdy,
  input  logic               lse_tick,
  output logic               css_fail
);

  localparam int TIMEOUT = `RCC_CSS_TIMEOUT;
  localparam int CW      = (TIMEOUT > 1) ? $clog2(TIMEOUT) : 1;

  logic          armed;
  logic          expire;
  logic [CW-1:0] cnt;

  // --------------------------------------------------
  // timeout counter
  // --------------------------------------------------

  // security on, oscillator on and reported ready
  assign armed = bdcr.lsecsson && bdcr.lseon && lse_rdy;

  // last silent cycle of the window
  assign expire = armed && !lse_tick && (cnt == CW'(TIMEOUT - 1));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt      <= '0;
      css_fail <= 1'b0;
    end else begin
      css_fail <= expire;
      // a tick or disarm restarts the window
      if (!armed || lse_tick || expire) begin
        cnt <= '0;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  // counter restart keeps the pulse to one cycle
  a_fail_pulse : assert property (
    @(posedge clk) disable iff (!arst_n)
    css_fail |=> !css_fail
  );

endmodule

// ==== design/rcc_vsw_top.sv ====
module rcc_vsw_top (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               req_valid,
  output logic               req_ready,
  input  rcc_pkg::rcc_req_t  req,
  input  logic               dbp,
  output logic               rsp_valid,
  input  logic               rsp_ready,
  output rcc_pkg::rcc_rsp_t  rsp,
  input  logic               lse_rdy,
  input  logic               lse_tick,
  output rcc_pkg::rcc_bdcr_t bdcr
);

  // producer to buffer
  logic              push_valid;
  logic              push_ready;
  rcc_pkg::rcc_req_t push_req;
  // buffer to register block
  logic              pop_valid;
  logic              pop_ready;
  rcc_pkg::rcc_req_t pop_req;
  // monitor to register block
  logic              css_fail;

  // --------------------------------------------------
  // request path
  // --------------------------------------------------

  rcc_bus_if u_bus_if (
    .clk, .arst_n, .req_valid, .req_ready, .req, .dbp,
    .push_valid, .push_ready, .push_req
  );

  rcc_req_fifo u_req_fifo (
    .clk, .arst_n, .push_valid, .push_ready, .push_req,
    .pop_valid, .pop_ready, .pop_req
  );

  // --------------------------------------------------
  // register block and clock security
  // --------------------------------------------------

  rcc_vsw_reg u_vsw_reg (
    .clk, .arst_n, .pop_valid, .pop_ready, .pop_req, .css_fail,
    .lse_rdy, .rsp_valid, .rsp_ready, .rsp, .bdcr
  );

  rcc_lse_css u_lse_css (
    .clk, .arst_n, .bdcr, .lse_rdy, .lse_tick, .css_fail
  );

endmodule

// ==== bench/tb_rcc_model_pkg.sv ====
`include "rcc_defs.svh"

package tb_rcc_model_pkg;

  // --------------------------------------------------
  // register state of the model
  // --------------------------------------------------

  // field image plus the two access locks
  typedef struct packed {
    rcc_pkg::rcc_bdcr_t f;
    logic               rtcsel_locked;
    logic               css_on_locked;
  } reg_state_t;

  // bus side keeps writable bits only
  function automatic logic [`RCC_BDCR_W-1:0] mask_wdata(logic [`RCC_BDCR_W-1:0] d);
    return d & `RCC_BDCR_RSVD_MASK;
  endfunction

  // one clock edge of the register block
  // a failure at the edge opens the locks before the write is judged
  function automatic reg_state_t reg_edge(reg_state_t s, logic wr, rcc_pkg::rcc_req_t r,
                                          logic fail);
    reg_state_t             n;
    logic [`RCC_BDCR_W-1:0] d;
    n = s;
    d = r.wdata;
    if (fail) begin
      n.f.lsecssd     = 1'b1;
      n.rtcsel_locked = 1'b0;
      n.css_on_locked = 1'b0;
    end
    if (wr && r.be[2]) begin
      n.f.bdrst = d[16];
    end
    if (wr && r.be[1]) begin
      n.f.rtcen = d[15];
      // write-once source select
      if (!n.rtcsel_locked) begin
        n.f.rtcsel      = rcc_pkg::rcc_rtcsel_e'(d[9:8]);
        n.rtcsel_locked = |d[9:8];
      end
    end
    if (wr && r.be[0]) begin
      n.f.lseon  = d[0];
      n.f.lsebyp = d[2];
      n.f.lsedrv = d[4:3];
      // set-only security enable
      if (!n.css_on_locked) begin
        n.f.lsecsson    = d[5];
        n.css_on_locked = d[5];
      end
    end
    return n;
  endfunction

  // bdcr as a read returns it
  function automatic logic [`RCC_BDCR_W-1:0] read_image(reg_state_t s, logic rdy);
    logic [`RCC_BDCR_W-1:0] v;
    v      = '0;
    v[0]   = s.f.lseon;
    v[1]   = rdy;
    v[2]   = s.f.lsebyp;
    v[4:3] = s.f.lsedrv;
    v[5]   = s.f.lsecsson;
    v[6]   = s.f.lsecssd;
    v[9:8] = s.f.rtcsel;
    v[15]  = s.f.rtcen;
    v[16]  = s.f.bdrst;
    return v;
  endfunction

endpackage

// ==== bench/tb_rcc_vsw.sv ====
`include "rcc_defs.svh"

module tb_rcc_vsw;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_CYCLES  = 6000;
  localparam int DRAIN_LIMIT = 200;

  logic clk;
  logic arst_n;
  logic req_valid;
  logic req_ready;
  rcc_pkg::rcc_req_t  req;
  logic dbp;
  logic rsp_valid;
  logic rsp_ready;
  rcc_pkg::rcc_rsp_t  rsp;
  logic lse_rdy;
  logic lse_tick;
  rcc_pkg::rcc_bdcr_t bdcr;

  // model of the whole request path
  tb_rcc_model_pkg::reg_state_t ms;
  logic stg_v;
  rcc_pkg::rcc_req_t stg_r;
  rcc_pkg::rcc_req_t fq[$];
  logic rsp_v_m;
  logic [`RCC_BDCR_W-1:0] rsp_d_m;
  int css_cnt;
  logic css_f_m;
  // bookkeeping
  int css_seen;
  int reads_sent;
  int rsp_count;
  bit req_done;
  bit tick_stop;
  int tick_phase;
  int t;

  rcc_vsw_top UUT (
    .clk, .arst_n, .req_valid, .req_ready, .req, .dbp,
    .rsp_valid, .rsp_ready, .rsp, .lse_rdy, .lse_tick, .bdcr
  );

  always #4 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERR %s expected %0h actual %0h", name, exp, act);
      $display("Checks failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // --------------------------------------------------
  // cycle model sampled mid-cycle
  // --------------------------------------------------

  task automatic model_cycle();
    logic push_rdy;
    logic pop_fire;
    logic push_fire;
    logic armed;
    logic expire;
    rcc_pkg::rcc_req_t head;
    push_rdy = (fq.size() < `RCC_FIFO_DEPTH);
    check_value("req_ready", !stg_v || push_rdy, req_ready);
    check_value("rsp_valid", rsp_v_m, rsp_valid);
    if (rsp_v_m) begin
      check_value("rsp_rdata", rsp_d_m, rsp.rdata);
    end
    check_value("bdcr", ms.f, bdcr);
    pop_fire  = (fq.size() > 0) && (!rsp_v_m || rsp_ready);
    push_fire = stg_v && push_rdy;
    req_done  = req_valid && (!stg_v || push_rdy);
    head      = (fq.size() > 0) ? fq[0] : '0;
    // responses actually taken from the dut
    if (rsp_valid && rsp_ready) begin
      rsp_count++;
    end
    // css window on the field state before this edge
    armed  = ms.f.lsecsson && ms.f.lseon && lse_rdy;
    expire = armed && !lse_tick && (css_cnt == `RCC_CSS_TIMEOUT - 1);
    // register block and response channel
    if (pop_fire && head.op == rcc_pkg::op_read) begin
      rsp_d_m = tb_rcc_model_pkg::read_image(ms, lse_rdy);
      rsp_v_m = 1'b1;
    end else if (rsp_ready) begin
      rsp_v_m = 1'b0;
    end
    ms = tb_rcc_model_pkg::reg_edge(ms, pop_fire && head.op == rcc_pkg::op_write, head, css_f_m);
    if (css_f_m) begin
      css_seen++;
    end
    css_f_m = expire;
    css_cnt = (!armed || lse_tick || expire) ? 0 : css_cnt + 1;
    // buffer then producer stage
    if (pop_fire) begin
      void'(fq.pop_front());
    end
    if (push_fire) begin
      fq.push_back(stg_r);
    end
    if (req_done && (req.op == rcc_pkg::op_read || dbp)) begin
      stg_v = 1'b1;
      stg_r = req;
      if (req.op == rcc_pkg::op_write) begin
        stg_r.wdata = tb_rcc_model_pkg::mask_wdata(req.wdata);
      end
      if (req.op == rcc_pkg::op_read) begin
        reads_sent++;
      end
    end else if (push_rdy) begin
      stg_v = 1'b0;
    end
  endtask

  // --------------------------------------------------
  // stimulus just after the rising edge
  // --------------------------------------------------

  task automatic drive_inputs(input bit stop);
    // payload held until the transfer
    if (!req_valid || req_done) begin
      req_valid = !stop && ($urandom_range(99) < 60);
      req.op    = rcc_pkg::rcc_op_e'($urandom_range(1));
      req.be    = 3'($urandom());
      req.wdata = `RCC_BDCR_W'($urandom());
    end
    if ($urandom_range(31) == 0) begin
      dbp = ($urandom_range(3) != 0);
    end
    rsp_ready = stop || ($urandom_range(99) < 65);
    // ready drops rarely and comes back fast
    if (lse_rdy) begin
      lse_rdy = ($urandom_range(299) != 0);
    end else begin
      lse_rdy = ($urandom_range(19) == 0);
    end
    // long silent windows trip the monitor
    if ($urandom_range(63) == 0) begin
      tick_stop = !tick_stop;
    end
    tick_phase = (tick_phase + 1) % 5;
    lse_tick   = !tick_stop && (tick_phase == 0);
  endtask

  initial begin
    clk       = 1'b0;
    arst_n    = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    dbp       = 1'b0;
    rsp_ready = 1'b0;
    lse_rdy   = 1'b0;
    lse_tick  = 1'b0;
    ms        = '0;
    stg_v     = 1'b0;
    stg_r     = '0;
    rsp_v_m   = 1'b0;
    rsp_d_m   = '0;
    css_cnt   = 0;
    css_f_m   = 1'b0;
    void'($urandom(14163));
    repeat (10) @(posedge clk);
    #1;
    arst_n    = 1'b1;
    // first request reads the reset image
    req_valid = 1'b1;
    req.op    = rcc_pkg::op_read;
    dbp       = 1'b1;
    rsp_ready = 1'b1;
    lse_rdy   = 1'b1;
    for (t = 0; t < NUM_CYCLES; t++) begin
      @(negedge clk);
      model_cycle();
      @(posedge clk);
      #1;
      drive_inputs(1'b0);
    end
    // no new requests while in-flight items drain
    for (t = 0; t < DRAIN_LIMIT; t++) begin
      @(negedge clk);
      model_cycle();
      if (!req_valid && !stg_v && fq.size() == 0 && !rsp_valid) begin
        break;
      end
      @(posedge clk);
      #1;
      drive_inputs(1'b1);
    end
    if (t == DRAIN_LIMIT) begin
      $display("timed out waiting for outstanding reads to drain");
      $display("Checks failed");
      $fatal(1, "drain timeout");
    end else begin
      check_value("rsp_count", reads_sent, rsp_count);
      check_value("css_seen", 1, css_seen > 0);
      $display("All checks passed");
      $finish;
    end
  end

endmodule

// ==== files.f ====
+incdir+include
design/rcc_pkg.sv
design/rcc_bus_if.sv
design/rcc_req_fifo.sv
design/rcc_vsw_reg.sv
design/rcc_lse_css.sv
design/rcc_vsw_top.sv
bench/tb_rcc_model_pkg.sv
bench/tb_rcc_vsw.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the bdcr testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_rcc_vsw -Mdir obj_dir -f files.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/Vtb_rcc_vsw > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "All checks passed" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
